//--- hw/dfe_ctrl_settings.svh
// Build-time settings of the link-equalization sequencer
// Channel count and index width, synchronizer depth
// Rate debounce length, skew limit and settle timer thresholds
`ifndef DFE_CTRL_SETTINGS_SVH
`define DFE_CTRL_SETTINGS_SVH

////////////////////
// Channels
////////////////////

// Receiver channels served in turn
`define DFE_NUM_CHANNELS 8
// Width of the channel index
`define DFE_CHAN_BITS 3

////////////////////
// Input side
////////////////////

// Flops in each synchronizer chain
`define DFE_SYNC_STAGES 3
// Cycles a changed rate request must hold before adoption
`define DFE_RATE_FILTER 8
// Saturating value of the skew counter after detect
`define DFE_SKEW_LIMIT 7

////////////////////
// Settle timers
////////////////////

`define DFE_TIMER_BITS 21
// About 12 ms at 100 MHz before the CTLE run
`define DFE_CTLE_WAIT_LONG 1200000
`define DFE_CTLE_WAIT_SHORT 1200
// About 10 ms at 100 MHz before the DFE run
`define DFE_DFE_WAIT_LONG 1000000
`define DFE_DFE_WAIT_SHORT 1000

`endif

//--- hw/dfe_ctrl_pkg.sv
// Shared types of the link-equalization sequencer
// Rate code, training status, step commands, sequencer states
// Channel index
`default_nettype none

`include "dfe_ctrl_settings.svh"

package dfe_ctrl_pkg;

  // Soft rate encoding, 2'b10 is Gen3 and all else Gen1/2
  typedef logic [1:0] pcie_rate_t;

  localparam pcie_rate_t RATE_GEN3 = 2'b10;

  // Link training state bits as seen from the PCIe core
  typedef struct packed {
    logic detect_quiet;
    logic detect_active;
    logic rcvr_phase_two;
  } ltssm_status_t;

  // Step handed to the reconfiguration engine
  typedef enum logic [2:0] {
    STEP_NONE,
    STEP_SW_GEN12,
    STEP_SW_GEN3,
    STEP_RESTORE_MODEB,
    STEP_PHASE2_CTLE,
    STEP_PHASE2_DFE
  } step_cmd_t;

  // Sequencer FSM states
  typedef enum logic [3:0] {
    IDLE,
    EXEC_RATE_SW,
    RESTORE_MODEB,
    WAIT_CTLE,
    EXEC_CTLE,
    WAIT_DFE,
    EXEC_DFE
  } seq_state_t;

  // Index of the channel under reconfiguration
  typedef logic [`DFE_CHAN_BITS-1:0] chan_idx_t;

endpackage

`default_nettype wire

//--- hw/sync_chain.sv
// Multi-stage synchronizer for an asynchronous level
// Payload given by a type parameter, cleared on reset
`timescale 1ns/100ps
`default_nettype none

`include "dfe_ctrl_settings.svh"

module sync_chain #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     reset_sync,
  input  payload_t d,
  output payload_t q
);

  // Register chain, stage 0 samples the raw input
  payload_t stage [`DFE_SYNC_STAGES];

  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      for (int i = 0; i < `DFE_SYNC_STAGES; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= d;
      // Shift towards the output
      for (int i = 1; i < `DFE_SYNC_STAGES; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // Last flop drives the synchronized level
  assign q = stage[`DFE_SYNC_STAGES-1];

endmodule

`default_nettype wire

//--- hw/link_status_if.sv
// Filtered link status between the monitor and the sequencer
// Debounced rate, synced detect quiet and phase two, skew timeout
`timescale 1ns/100ps
`default_nettype none

interface link_status_if import dfe_ctrl_pkg::*; ();

  pcie_rate_t rate;
  logic       detect_quiet;
  logic       rcvr_phase_two;
  // High once the link has been out of detect long enough
  logic       skew_timeout;

  // Input side drives every level
  modport monitor (output rate, detect_quiet, rcvr_phase_two, skew_timeout);

  // FSM side only samples them
  modport sequencer (input rate, detect_quiet, rcvr_phase_two, skew_timeout);

endinterface

`default_nettype wire

//--- hw/link_monitor.sv
// Input side of the sequencer
// Training-state and rate synchronizers, rate debounce
// Skew counter after the link leaves detect
`timescale 1ns/100ps
`default_nettype none

`include "dfe_ctrl_settings.svh"

module link_monitor import dfe_ctrl_pkg::*; (
  input  logic                  clock,
  input  logic                  reset_sync,
  input  logic                  ltssm_detect_quiet,
  input  logic                  ltssm_detect_active,
  input  logic                  ltssm_rcvr_phase_two,
  input  pcie_rate_t            pcie_rate_sw,
  link_status_if.monitor        status
);

  localparam int FILT_BITS = $clog2(`DFE_RATE_FILTER + 1);
  localparam int SKEW_BITS = $clog2(`DFE_SKEW_LIMIT + 1);

  ltssm_status_t          ltssm_raw;
  ltssm_status_t          ltssm_sync;
  pcie_rate_t             rate_sync;
  pcie_rate_t             rate_prev;
  pcie_rate_t             rate_r;
  logic [FILT_BITS-1:0]   filt_cnt;
  logic [SKEW_BITS-1:0]   skew_cnt;
  logic                   in_detect;
  logic                   skew_full;

  ////////////////////
  // Synchronizers
  ////////////////////

  assign ltssm_raw = '{detect_quiet:   ltssm_detect_quiet,
                       detect_active:  ltssm_detect_active,
                       rcvr_phase_two: ltssm_rcvr_phase_two};

  sync_chain #(.payload_t(ltssm_status_t)) i_ltssm_sync (
    .clock      (clock),
    .reset_sync (reset_sync),
    .d          (ltssm_raw),
    .q          (ltssm_sync)
  );

  sync_chain #(.payload_t(pcie_rate_t)) i_rate_sync (
    .clock      (clock),
    .reset_sync (reset_sync),
    .d          (pcie_rate_sw),
    .q          (rate_sync)
  );

  ////////////////////
  // Rate debounce
  ////////////////////

  // Restart the count on any new sample or when the request matches
  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      rate_prev <= '0;
      rate_r    <= '0;
      filt_cnt  <= '0;
    end else begin
      rate_prev <= rate_sync;
      if (rate_sync == rate_r || rate_sync != rate_prev) begin
        filt_cnt <= '0;
      end else if (filt_cnt == FILT_BITS'(`DFE_RATE_FILTER)) begin
        // Stable long enough, adopt it
        rate_r   <= rate_sync;
        filt_cnt <= '0;
      end else begin
        filt_cnt <= filt_cnt + 1'b1;
      end
    end
  end

  ////////////////////
  // Skew counter
  ////////////////////

  assign in_detect = ltssm_sync.detect_quiet | ltssm_sync.detect_active;
  assign skew_full = (skew_cnt == SKEW_BITS'(`DFE_SKEW_LIMIT));

  // Counts while outside detect, holds at the limit
  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      skew_cnt <= '0;
    end else if (in_detect) begin
      skew_cnt <= '0;
    end else if (!skew_full) begin
      skew_cnt <= skew_cnt + 1'b1;
    end
  end

  assign status.rate           = rate_r;
  assign status.detect_quiet   = ltssm_sync.detect_quiet;
  assign status.rcvr_phase_two = ltssm_sync.rcvr_phase_two;
  assign status.skew_timeout   = skew_full;

  a_skew_bound: assert property (@(posedge clock) disable iff (reset_sync)
    skew_cnt <= SKEW_BITS'(`DFE_SKEW_LIMIT));

endmodule

`default_nettype wire

//--- hw/adapt_sequencer.sv
// Equalization sequencer FSM
// Rate switch, mode-B restore and phase-two CTLE/DFE rounds
// Settle timer with full or reduced thresholds, reconfiguration lock
`timescale 1ns/100ps
`default_nettype none

`include "dfe_ctrl_settings.svh"

module adapt_sequencer import dfe_ctrl_pkg::*; (
  input  logic                    clock,
  input  logic                    reset_sync,
  link_status_if.sequencer        status,
  input  logic                    reduce_counters,
  input  logic                    all_done,
  output logic                    step_go,
  output step_cmd_t               step_cmd,
  output logic                    reconfig_lock
);

  seq_state_t                  state;
  pcie_rate_t                  current_rate;
  // Restore still owed after the last detect exit
  logic                        modeb_armed;
  // Phase-two flow not yet run for this request
  logic                        phase2_armed;
  logic [`DFE_TIMER_BITS-1:0]  timer;
  logic [`DFE_TIMER_BITS-1:0]  ctle_wait;
  logic [`DFE_TIMER_BITS-1:0]  dfe_wait;
  logic [`DFE_TIMER_BITS-1:0]  wait_limit;

  ////////////////////
  // Settle thresholds
  ////////////////////

  assign ctle_wait = reduce_counters ? `DFE_TIMER_BITS'(`DFE_CTLE_WAIT_SHORT)
                                     : `DFE_TIMER_BITS'(`DFE_CTLE_WAIT_LONG);
  assign dfe_wait  = reduce_counters ? `DFE_TIMER_BITS'(`DFE_DFE_WAIT_SHORT)
                                     : `DFE_TIMER_BITS'(`DFE_DFE_WAIT_LONG);
  assign wait_limit = (state == WAIT_CTLE) ? ctle_wait : dfe_wait;

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      state        <= IDLE;
      current_rate <= '0;
      modeb_armed  <= 1'b0;
      phase2_armed <= 1'b0;
      timer        <= '0;
    end else begin
      // Timer only runs in the two WAIT states
      timer <= '0;
      case (state)
        IDLE: begin
          current_rate <= status.rate;
          if (status.skew_timeout) begin
            modeb_armed <= 1'b1;
          end
          if (!status.rcvr_phase_two) begin
            phase2_armed <= 1'b1;
          end
          // Rate change wins over the restore request
          if (status.rate != current_rate) begin
            state <= EXEC_RATE_SW;
          end else if ((status.detect_quiet && modeb_armed) ||
                       (status.rcvr_phase_two && phase2_armed)) begin
            state <= RESTORE_MODEB;
          end
        end
        EXEC_RATE_SW: begin
          if (all_done) begin
            state <= IDLE;
          end
        end
        RESTORE_MODEB: begin
          modeb_armed <= 1'b0;
          if (all_done) begin
            state <= status.rcvr_phase_two ? WAIT_CTLE : IDLE;
          end
        end
        WAIT_CTLE, WAIT_DFE: begin
          if (timer == wait_limit) begin
            state <= (state == WAIT_CTLE) ? EXEC_CTLE : EXEC_DFE;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        EXEC_CTLE: begin
          if (all_done) begin
            state <= WAIT_DFE;
          end
        end
        EXEC_DFE: begin
          // Flow has run, wait for phase two to drop before rearming
          phase2_armed <= 1'b0;
          if (all_done) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // Step outputs
  ////////////////////

  always_comb begin
    step_cmd = STEP_NONE;
    case (state)
      EXEC_RATE_SW:  step_cmd = (current_rate == RATE_GEN3) ? STEP_SW_GEN3 : STEP_SW_GEN12;
      RESTORE_MODEB: step_cmd = STEP_RESTORE_MODEB;
      EXEC_CTLE:     step_cmd = STEP_PHASE2_CTLE;
      EXEC_DFE:      step_cmd = STEP_PHASE2_DFE;
      default:       step_cmd = STEP_NONE;
    endcase
  end

  // Go for every state that walks the channels
  assign step_go       = (step_cmd != STEP_NONE);
  assign reconfig_lock = (state != IDLE);

  a_no_go_in_wait: assert property (@(posedge clock) disable iff (reset_sync)
    (state inside {WAIT_CTLE, WAIT_DFE}) |-> !step_go);

  a_legal_state: assert property (@(posedge clock) disable iff (reset_sync)
    state inside {IDLE, EXEC_RATE_SW, RESTORE_MODEB, WAIT_CTLE, EXEC_CTLE,
                  WAIT_DFE, EXEC_DFE});

endmodule

`default_nettype wire

//--- hw/channel_stepper.sv
// Channel stepper for the reconfiguration engine
// Running-edge detection, channel index, round completion pulse
`timescale 1ns/100ps
`default_nettype none

`include "dfe_ctrl_settings.svh"

module channel_stepper import dfe_ctrl_pkg::*; (
  input  logic      clock,
  input  logic      reset_sync,
  input  logic      step_go,
  input  logic      step_running,
  output logic      all_done,
  output chan_idx_t step_channel
);

  localparam chan_idx_t LAST_CHAN = chan_idx_t'(`DFE_NUM_CHANNELS - 1);

  logic running_q;
  logic step_done;

  ////////////////////
  // Completion detect
  ////////////////////

  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      running_q <= 1'b0;
    end else begin
      running_q <= step_running;
    end
  end

  // Falling edge of running while a round is active
  assign step_done = step_go && running_q && !step_running;

  // Last channel finished, the round is over
  assign all_done = step_done && (step_channel == LAST_CHAN);

  ////////////////////
  // Channel index
  ////////////////////

  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      step_channel <= '0;
    end else if (!step_go) begin
      // Next round starts at channel 0
      step_channel <= '0;
    end else if (step_done && step_channel != LAST_CHAN) begin
      step_channel <= step_channel + 1'b1;
    end
  end

  a_chan_bound: assert property (@(posedge clock) disable iff (reset_sync)
    step_channel <= LAST_CHAN);

endmodule

`default_nettype wire

//--- hw/dfe_ctrl_top.sv
// Top level of the link-equalization sequencer
// Link monitor, sequencer FSM and channel stepper
// Step command interface to the external reconfiguration engine
`timescale 1ns/100ps
`default_nettype none

module dfe_ctrl_top import dfe_ctrl_pkg::*; (
  input  logic       clock,
  input  logic       reset_sync,
  input  logic       ltssm_detect_quiet,
  input  logic       ltssm_detect_active,
  input  logic       ltssm_rcvr_phase_two,
  input  pcie_rate_t pcie_rate_sw,
  input  logic       reduce_counters,
  input  logic       step_running,
  output logic       step_go,
  output step_cmd_t  step_cmd,
  output chan_idx_t  step_channel,
  output logic       reconfig_lock
);

  // Round finished on the last channel
  logic all_done;

  link_status_if i_link_status ();

  link_monitor i_link_monitor (
    .clock                (clock),
    .reset_sync           (reset_sync),
    .ltssm_detect_quiet   (ltssm_detect_quiet),
    .ltssm_detect_active  (ltssm_detect_active),
    .ltssm_rcvr_phase_two (ltssm_rcvr_phase_two),
    .pcie_rate_sw         (pcie_rate_sw),
    .status               (i_link_status.monitor)
  );

  adapt_sequencer i_adapt_sequencer (
    .clock           (clock),
    .reset_sync      (reset_sync),
    .status          (i_link_status.sequencer),
    .reduce_counters (reduce_counters),
    .all_done        (all_done),
    .step_go         (step_go),
    .step_cmd        (step_cmd),
    .reconfig_lock   (reconfig_lock)
  );

  channel_stepper i_channel_stepper (
    .clock        (clock),
    .reset_sync   (reset_sync),
    .step_go      (step_go),
    .step_running (step_running),
    .all_done     (all_done),
    .step_channel (step_channel)
  );

endmodule

`default_nettype wire

//--- testbench/tb_dfe_ctrl.sv
// Testbench for the link-equalization sequencer
// Stimulus table applied row by row, reconfiguration-engine model
// Typed compare tasks, step log checks, cycle-count timeout
`timescale 1ns/100ps
`default_nettype none

`include "dfe_ctrl_settings.svh"

module tb_dfe_ctrl import dfe_ctrl_pkg::*; ();

  localparam int DRIVE_DELAY = 5;
  localparam int MAX_ROWS    = 16;
  localparam int LOG_DEPTH   = 32;
  localparam int NCH         = `DFE_NUM_CHANNELS;

  // One stimulus row, expected rounds of eight steps each
  typedef struct packed {
    logic       dq;
    logic       da;
    logic       p2;
    pcie_rate_t rate;
    int         hold;
    int         rounds;
    step_cmd_t  cmd0;
    step_cmd_t  cmd1;
    step_cmd_t  cmd2;
  } row_t;

  logic       clock;
  logic       reset_sync;
  logic       ltssm_detect_quiet;
  logic       ltssm_detect_active;
  logic       ltssm_rcvr_phase_two;
  pcie_rate_t pcie_rate_sw;
  logic       step_running;
  logic       step_go;
  step_cmd_t  step_cmd;
  chan_idx_t  step_channel;
  logic       reconfig_lock;

  row_t        stim [MAX_ROWS];
  int          row_count = 0;
  int          cycle_count = 0;
  int          timeout_limit = 0;
  // Engine step log, filled at step start and end
  step_cmd_t   log_cmd [LOG_DEPTH];
  chan_idx_t   log_chan [LOG_DEPTH];
  int          log_start [LOG_DEPTH];
  int          log_end [LOG_DEPTH];
  int          log_count = 0;
  int          lock_rises = 0;
  logic        lock_prev = 1'b0;
  logic [31:0] rng_state = 32'hd14f877a;
  int          run_left = 0;
  int          idle_cycles = 0;

  dfe_ctrl_top i_dfe_ctrl_top (
    .clock                (clock),
    .reset_sync           (reset_sync),
    .ltssm_detect_quiet   (ltssm_detect_quiet),
    .ltssm_detect_active  (ltssm_detect_active),
    .ltssm_rcvr_phase_two (ltssm_rcvr_phase_two),
    .pcie_rate_sw         (pcie_rate_sw),
    .reduce_counters      (1'b1),
    .step_running         (step_running),
    .step_go              (step_go),
    .step_cmd             (step_cmd),
    .step_channel         (step_channel),
    .reconfig_lock        (reconfig_lock)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) cycle_count <= cycle_count + 1;

  ////////////////////
  // Checks
  ////////////////////

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare_cmd(input string name, input step_cmd_t act, input step_cmd_t exp);
    if (act !== exp) report_error($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, act, exp));
  endtask

  task automatic compare_channel(input string name, input chan_idx_t act, input chan_idx_t exp);
    if (act !== exp) report_error($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, act, exp));
  endtask

  task automatic compare_bit(input string name, input logic act, input logic exp);
    if (act !== exp) report_error($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, act, exp));
  endtask

  // Numerical Recipes LCG step
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic step_cmd_t round_cmd(input row_t row, input int k);
    return (k == 0) ? row.cmd0 : (k == 1) ? row.cmd1 : row.cmd2;
  endfunction

  task automatic add_row(input logic dq, input logic da, input logic p2, input pcie_rate_t rate,
                         input int hold, input int rounds, input step_cmd_t c0,
                         input step_cmd_t c1, input step_cmd_t c2);
    stim[row_count] = '{dq, da, p2, rate, hold, rounds, c0, c1, c2};
    row_count++;
  endtask

  ////////////////////
  // Engine model
  ////////////////////

  // Starts a step after two idle cycles, runs it for 2 to 6 cycles
  task automatic run_engine_cycle();
    if (reconfig_lock && !lock_prev) lock_rises++;
    lock_prev = reconfig_lock;
    if (step_running) begin
      run_left--;
      if (run_left == 0) begin
        step_running = 1'b0;
        idle_cycles = 0;
        if (log_count > 0 && log_count <= LOG_DEPTH) log_end[log_count-1] = cycle_count;
      end
    end else if (step_go && idle_cycles >= 2) begin
      compare_bit("reconfig_lock", reconfig_lock, 1'b1);
      if (log_count < LOG_DEPTH) begin
        log_cmd[log_count]   = step_cmd;
        log_chan[log_count]  = step_channel;
        log_start[log_count] = cycle_count;
      end
      log_count++;
      rng_state = lcg_next(rng_state);
      run_left = 2 + int'(rng_state[31:16] % 5);
      step_running = 1'b1;
    end else if (idle_cycles < 2) begin
      idle_cycles++;
    end
  endtask

  initial begin
    step_running = 1'b0;
    forever begin
      @(posedge clock);
      #DRIVE_DELAY;
      run_engine_cycle();
    end
  end

  ////////////////////
  // Row handling
  ////////////////////

  task automatic check_row(input row_t row);
    int expect_count;
    int expect_rises;
    int gap;
    expect_count = row.rounds * NCH;
    expect_rises = (row.rounds > 0) ? 1 : 0;
    if (log_count != expect_count)
      report_error($sformatf("Expected %0d steps in the row but the engine saw %0d",
                             expect_count, log_count));
    for (int i = 0; i < log_count; i++) begin
      compare_cmd("step_cmd", log_cmd[i], round_cmd(row, i / NCH));
      compare_channel("step_channel", log_chan[i], chan_idx_t'(i % NCH));
      if (i > 0) begin
        gap = log_start[i] - log_end[i-1];
        if (log_cmd[i] == STEP_PHASE2_CTLE && log_cmd[i-1] == STEP_RESTORE_MODEB &&
            gap < `DFE_CTLE_WAIT_SHORT)
          report_error($sformatf("CTLE round started only %0d cycles after the restore", gap));
        if (log_cmd[i] == STEP_PHASE2_DFE && log_cmd[i-1] == STEP_PHASE2_CTLE &&
            gap < `DFE_DFE_WAIT_SHORT)
          report_error($sformatf("DFE round started only %0d cycles after the CTLE run", gap));
      end
    end
    if (lock_rises != expect_rises)
      report_error($sformatf("Reconfig lock rose %0d times in the row, expected %0d",
                             lock_rises, expect_rises));
    compare_bit("reconfig_lock", reconfig_lock, 1'b0);
    compare_bit("step_go", step_go, 1'b0);
    compare_channel("step_channel", step_channel, '0);
    log_count = 0;
    lock_rises = 0;
  endtask

  initial begin
    reset_sync           = 1'b1;
    ltssm_detect_quiet   = 1'b0;
    ltssm_detect_active  = 1'b1;
    ltssm_rcvr_phase_two = 1'b0;
    pcie_rate_sw         = 2'b00;
    // dq da p2 rate hold rounds commands
    add_row(0, 1, 0, 2'b00,   50, 0, STEP_NONE, STEP_NONE, STEP_NONE);
    add_row(0, 1, 0, 2'b10,  200, 1, STEP_SW_GEN3, STEP_NONE, STEP_NONE);
    add_row(0, 1, 0, 2'b01,  200, 1, STEP_SW_GEN12, STEP_NONE, STEP_NONE);
    // Short rate glitch, then settle
    add_row(0, 1, 0, 2'b10,    3, 0, STEP_NONE, STEP_NONE, STEP_NONE);
    add_row(0, 1, 0, 2'b01,   50, 0, STEP_NONE, STEP_NONE, STEP_NONE);
    // Quiet while still in detect owes no restore
    add_row(1, 1, 0, 2'b01,   50, 0, STEP_NONE, STEP_NONE, STEP_NONE);
    // Out of detect past the skew limit, then quiet twice
    add_row(0, 0, 0, 2'b01,   40, 0, STEP_NONE, STEP_NONE, STEP_NONE);
    add_row(1, 0, 0, 2'b01,  200, 1, STEP_RESTORE_MODEB, STEP_NONE, STEP_NONE);
    add_row(1, 0, 0, 2'b01,  200, 0, STEP_NONE, STEP_NONE, STEP_NONE);
    // Phase-two flow, then held phase two
    add_row(0, 0, 1, 2'b01, 3000, 3, STEP_RESTORE_MODEB, STEP_PHASE2_CTLE, STEP_PHASE2_DFE);
    add_row(0, 0, 1, 2'b01,  300, 0, STEP_NONE, STEP_NONE, STEP_NONE);
    timeout_limit = 1000;
    for (int r = 0; r < row_count; r++) timeout_limit += stim[r].hold;

    repeat (10) @(posedge clock);
    #DRIVE_DELAY reset_sync = 1'b0;
    @(negedge clock);
    compare_bit("step_go", step_go, 1'b0);
    compare_cmd("step_cmd", step_cmd, STEP_NONE);
    compare_channel("step_channel", step_channel, '0);
    compare_bit("reconfig_lock", reconfig_lock, 1'b0);

    for (int r = 0; r < row_count; r++) begin
      @(posedge clock);
      #DRIVE_DELAY;
      ltssm_detect_quiet   = stim[r].dq;
      ltssm_detect_active  = stim[r].da;
      ltssm_rcvr_phase_two = stim[r].p2;
      pcie_rate_sw         = stim[r].rate;
      repeat (stim[r].hold) @(negedge clock);
      while (reconfig_lock) @(negedge clock);
      check_row(stim[r]);
    end

    @(negedge clock);
    if (log_count != 0 || reconfig_lock !== 1'b0) begin
      report_error("Engine saw steps or lock activity after the last row");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

  // Ends a run that stalls past the summed row hold times
  initial begin
    wait (timeout_limit != 0);
    while (cycle_count <= timeout_limit) @(posedge clock);
    report_error($sformatf("Timeout after %0d cycles, the sequencer never went idle",
                           cycle_count));
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hw
hw/dfe_ctrl_pkg.sv
hw/sync_chain.sv
hw/link_status_if.sv
hw/link_monitor.sv
hw/adapt_sequencer.sv
hw/channel_stepper.sv
hw/dfe_ctrl_top.sv
testbench/tb_dfe_ctrl.sv

//--- Bender.yml
package:
  name: dfe_ctrl

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/dfe_ctrl_pkg.sv
      - hw/sync_chain.sv
      - hw/link_status_if.sv
      - hw/link_monitor.sv
      - hw/adapt_sequencer.sv
      - hw/channel_stepper.sv
      - hw/dfe_ctrl_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - testbench/tb_dfe_ctrl.sv
